// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - riscv_pkg.sv
  - fetch_unit.sv
  - instr_queue.sv
  - decoder.sv
  - regfile.sv
  - execute_unit.sv
  - core.sv
  - target: simulation
    files:
      - tb_core.sv

// ==== core.sv ====
`timescale 1ns/1ns

module core (
   input  logic               clk,
   input  logic               rst_n,
   output logic               imem_req,
   output riscv_pkg::word_t   imem_addr,
   input  riscv_pkg::word_t   imem_data,
   output logic               retire_valid,
   input  logic               retire_ready,
   output riscv_pkg::retire_t retire
);
   import riscv_pkg::*;

   // ==============================
   // Internal nets
   // ==============================
   logic       fetch_valid;
   logic       fetch_ready;
   fetch_pkt_t fetch_pkt;
   logic       issue_valid;
   logic       issue_ready;
   fetch_pkt_t issue_pkt;
   redirect_t  redirect;     // Steers fetch and flushes the queue

   fetch_unit fetch0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (redirect),
      .imem_req    (imem_req),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .fetch_valid (fetch_valid),
      .fetch_pkt   (fetch_pkt),
      .fetch_ready (fetch_ready)
   );

   instr_queue queue0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (redirect.valid),
      .in_valid  (fetch_valid),
      .in_ready  (fetch_ready),
      .in_pkt    (fetch_pkt),
      .out_valid (issue_valid),
      .out_ready (issue_ready),
      .out_pkt   (issue_pkt)
   );

   execute_unit exec0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue_ready  (issue_ready),
      .issue_pkt    (issue_pkt),
      .redirect     (redirect),
      .retire_valid (retire_valid),
      .retire_ready (retire_ready),
      .retire       (retire)
   );

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ns

module decoder (
   input  riscv_pkg::fetch_pkt_t pkt,
   output riscv_pkg::decoded_t   dec
);
   import riscv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_u;
   word_t      imm_j;
   word_t      imm_b;

   assign opcode = pkt.instr[6:0];
   assign funct3 = pkt.instr[14:12];
   assign funct7 = pkt.instr[31:25];

   // ==============================
   // Immediate formats
   // ==============================
   assign imm_i = {{20{pkt.instr[31]}}, pkt.instr[31:20]};
   assign imm_u = {pkt.instr[31:12], 12'b0};
   assign imm_j = {{12{pkt.instr[31]}}, pkt.instr[19:12], pkt.instr[20],
                   pkt.instr[30:21], 1'b0};
   assign imm_b = {{20{pkt.instr[31]}}, pkt.instr[7], pkt.instr[30:25],
                   pkt.instr[11:8], 1'b0};

   always_comb begin
      dec        = '0;
      dec.pc     = pkt.pc;
      dec.rd     = pkt.instr[11:7];
      dec.rs1    = pkt.instr[19:15];
      dec.rs2    = pkt.instr[24:20];
      dec.alu_op = op_nop;    // Anything unrecognised retires as a no-op
      case (opcode)
         op_imm: begin
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            if (funct3 == funct3_add) begin   // ADDI only
               dec.alu_op    = op_add;
               dec.writes_rd = 1'b1;
            end
         end
         op_reg: begin
            if (funct3 == funct3_add && funct7 == funct7_add) begin
               dec.alu_op    = op_add;
               dec.writes_rd = 1'b1;
            end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
               dec.alu_op    = op_sub;
               dec.writes_rd = 1'b1;
            end
         end
         op_lui: begin
            dec.imm       = imm_u;
            dec.use_imm   = 1'b1;
            dec.alu_op    = op_pass_imm;
            dec.writes_rd = 1'b1;
         end
         op_jal: begin
            dec.imm       = imm_j;
            dec.alu_op    = op_link;
            dec.writes_rd = 1'b1;
         end
         op_branch: begin
            dec.imm = imm_b;  // Branches compare rs1 with rs2 and write nothing
            if (funct3 == funct3_beq) begin
               dec.alu_op = op_beq;
            end else if (funct3 == funct3_bne) begin
               dec.alu_op = op_bne;
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue_valid,
   output logic                  issue_ready,
   input  riscv_pkg::fetch_pkt_t issue_pkt,
   output riscv_pkg::redirect_t  redirect,
   output logic                  retire_valid,
   input  logic                  retire_ready,
   output riscv_pkg::retire_t    retire
);
   import riscv_pkg::*;

   decoded_t dec;
   word_t    rs1_val;
   word_t    rs2_val;
   word_t    operand_b;
   word_t    result;
   word_t    target;
   logic     taken;
   logic     wrote;
   logic     accept;
   logic     redirect_valid_q;
   word_t    redirect_target_q;

   decoder dec0 (
      .pkt (issue_pkt),
      .dec (dec)
   );

   // The write of one instruction lands on the edge that accepts the next,
   // so a dependent instruction reads the new value without forwarding
   regfile rf0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs1     (dec.rs1),
      .rs2     (dec.rs2),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .we      (accept && wrote),
      .wa      (dec.rd),
      .wd      (result)
   );

   assign issue_ready = !retire_valid || retire_ready;
   assign accept      = issue_valid && issue_ready;
   assign operand_b   = dec.use_imm ? dec.imm : rs2_val;
   assign target      = dec.pc + dec.imm;
   assign wrote       = dec.writes_rd && (dec.rd != '0);  // x0 writes are dropped

   // ==============================
   // ALU and branch resolution
   // ==============================
   always_comb begin
      result = '0;
      taken  = 1'b0;
      case (dec.alu_op)
         op_add:      result = rs1_val + operand_b;
         op_sub:      result = rs1_val - rs2_val;
         op_pass_imm: result = dec.imm;
         op_link: begin
            result = dec.pc + xlen_w'(4);
            taken  = 1'b1;
         end
         op_beq:      taken = (rs1_val == rs2_val);
         op_bne:      taken = (rs1_val != rs2_val);
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         retire_valid     <= 1'b0;
         redirect_valid_q <= 1'b0;
      end else begin
         if (accept) begin
            retire_valid <= 1'b1;
         end else if (retire_ready) begin
            retire_valid <= 1'b0;
         end
         redirect_valid_q <= accept && taken;  // Single-cycle pulse
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         retire.pc         <= dec.pc;
         retire.rd         <= wrote ? dec.rd : '0;
         retire.value      <= wrote ? result : '0;
         retire.wrote      <= wrote;
         redirect_target_q <= target;
      end
   end

   assign redirect.valid  = redirect_valid_q;
   assign redirect.target = redirect_target_q;

   a_retire_hold : assert property (@(posedge clk) disable iff (!rst_n)
      retire_valid && !retire_ready |=> retire_valid && $stable(retire))
      else $error("retire record changed while stalled");

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  riscv_pkg::redirect_t  redirect,
   output logic                  imem_req,
   output riscv_pkg::word_t      imem_addr,
   input  riscv_pkg::word_t      imem_data,
   output logic                  fetch_valid,
   output riscv_pkg::fetch_pkt_t fetch_pkt,
   input  logic                  fetch_ready
);
   import riscv_pkg::*;

   word_t      pc_q;          // Address of the next request
   word_t      pend_pc_q;     // Address of the request in flight
   logic       pend_q;        // A response arrives this cycle
   logic       started_q;
   logic       hold_valid_q;
   fetch_pkt_t hold_pkt_q;
   fetch_pkt_t resp_pkt;
   logic       out_free;

   // The memory answers one cycle after the request, so the response is
   // offered straight from imem_data and only parked when it is not taken
   assign resp_pkt.pc    = pend_pc_q;
   assign resp_pkt.instr = imem_data;

   assign fetch_valid = (hold_valid_q || pend_q) && !redirect.valid;
   assign fetch_pkt   = hold_valid_q ? hold_pkt_q : resp_pkt;

   // Room for a new response next cycle
   assign out_free = !fetch_valid || fetch_ready;

   assign imem_req  = started_q && out_free && !redirect.valid;
   assign imem_addr = pc_q;

   // ==============================
   // Control state
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q         <= reset_pc;
         pend_q       <= 1'b0;
         started_q    <= 1'b0;
         hold_valid_q <= 1'b0;
      end else begin
         started_q <= 1'b1;
         if (redirect.valid) begin
            pc_q         <= redirect.target;
            pend_q       <= 1'b0;                  // Drop the wrong-path response
            hold_valid_q <= 1'b0;
         end else begin
            pend_q       <= imem_req;
            hold_valid_q <= fetch_valid && !fetch_ready;
            if (imem_req) begin
               pc_q <= pc_q + xlen_w'(4);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (imem_req) begin
         pend_pc_q <= pc_q;
      end
      if (fetch_valid && !fetch_ready) begin
         hold_pkt_q <= fetch_pkt;  // Same value the consumer already sees
      end
   end

   // A stalled packet stays on the port until taken or flushed
   a_pkt_stable : assert property (@(posedge clk) disable iff (!rst_n)
      fetch_valid && !fetch_ready |=> $stable(fetch_pkt) && (fetch_valid || redirect.valid))
      else $error("fetch packet changed while stalled");

endmodule

// ==== instr_queue.sv ====
`timescale 1ns/1ns

module instr_queue (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  riscv_pkg::fetch_pkt_t in_pkt,
   output logic                  out_valid,
   input  logic                  out_ready,
   output riscv_pkg::fetch_pkt_t out_pkt
);
   import riscv_pkg::*;

   fetch_pkt_t             mem [queue_depth];
   logic [queue_ptr_w-1:0] wr_ptr;
   logic [queue_ptr_w-1:0] rd_ptr;
   logic [queue_cnt_w-1:0] count;
   logic                   push;
   logic                   pop;

   assign in_ready  = (count != queue_cnt_w'(queue_depth));
   assign out_valid = (count != '0) && !flush;  // Entries are wrong-path during a flush
   assign out_pkt   = mem[rd_ptr];

   assign push = in_valid && in_ready && !flush;
   assign pop  = out_valid && out_ready;

   // ==============================
   // Pointers and count
   // ==============================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_pkt;
      end
   end

   a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
      count <= queue_cnt_w'(queue_depth))
      else $error("queue count above depth");

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  riscv_pkg::reg_addr_t rs1,
   input  riscv_pkg::reg_addr_t rs2,
   output riscv_pkg::word_t     rs1_val,
   output riscv_pkg::word_t     rs2_val,
   input  logic                 we,
   input  riscv_pkg::reg_addr_t wa,
   input  riscv_pkg::word_t     wd
);
   import riscv_pkg::*;

   word_t regs [reg_count];

   // Reads are asynchronous and x0 is hardwired
   assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wa != '0) begin
         regs[wa] <= wd;
      end
   end

endmodule

// ==== riscv_pkg.sv ====
package riscv_pkg;

   // ==============================
   // Sizes and constants
   // ==============================
   localparam int xlen_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int reg_count   = 1 << reg_addr_w;
   localparam int queue_depth = 2;
   localparam int queue_ptr_w = $clog2(queue_depth);
   localparam int queue_cnt_w = $clog2(queue_depth + 1);  // Must hold the value queue_depth

   typedef logic [xlen_w-1:0]     word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   localparam word_t reset_pc = '0;

   // ==============================
   // Instruction encodings
   // ==============================
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;

   localparam logic [2:0] funct3_add = 3'b000;  // Shared by ADDI, ADD and SUB
   localparam logic [2:0] funct3_beq = 3'b000;
   localparam logic [2:0] funct3_bne = 3'b001;
   localparam logic [6:0] funct7_add = 7'b0000000;
   localparam logic [6:0] funct7_sub = 7'b0100000;

   // ==============================
   // Types
   // ==============================
   typedef struct packed {
      word_t pc;
      word_t instr;
   } fetch_pkt_t;

   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_pass_imm,
      op_link,
      op_beq,
      op_bne,
      op_nop
   } alu_op_e;

   typedef struct packed {
      word_t     pc;
      alu_op_e   alu_op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     imm;
      logic      use_imm;    // Second operand is the immediate and not rs2
      logic      writes_rd;
   } decoded_t;

   typedef struct packed {
      logic  valid;
      word_t target;
   } redirect_t;

   typedef struct packed {
      word_t     pc;
      reg_addr_t rd;
      word_t     value;
      logic      wrote;
   } retire_t;

endpackage

// ==== src.f ====
riscv_pkg.sv
fetch_unit.sv
instr_queue.sv
decoder.sv
regfile.sv
execute_unit.sv
core.sv
tb_core.sv

// ==== tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
   import riscv_pkg::*;

   localparam int clk_period     = 40;
   localparam int reset_cycles   = 10;
   localparam int n_rows         = 18;
   localparam int imem_words     = 64;
   localparam int timeout_cycles = n_rows * 16 + reset_cycles;

   logic    clk;
   logic    rst_n;
   logic    imem_req;
   word_t   imem_addr;
   word_t   imem_data;
   logic    retire_valid;
   logic    retire_ready;
   retire_t retire;

   word_t       imem [imem_words];
   retire_t     exp_tab [n_rows];   // Expected retire records in program order
   word_t       redir_q [$];        // Expected fetch targets after each redirect
   logic [15:0] lfsr;
   int          errors;
   logic        redirect_seen;
   logic        stall_seen;
   logic        first_req_done;
   retire_t     held;

   core dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .imem_req     (imem_req),
      .imem_addr    (imem_addr),
      .imem_data    (imem_data),
      .retire_valid (retire_valid),
      .retire_ready (retire_ready),
      .retire       (retire)
   );

   // ==============================
   // Instruction encoders
   // ==============================
   function automatic word_t enc_i(word_t imm, reg_addr_t rs1, reg_addr_t rd);
      return {imm[11:0], rs1, funct3_add, rd, op_imm};   // ADDI
   endfunction

   function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1, reg_addr_t rd);
      return {f7, rs2, rs1, funct3_add, rd, op_reg};
   endfunction

   function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd);
      return {imm, rd, op_lui};
   endfunction

   function automatic word_t enc_j(word_t off, reg_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
   endfunction

   function automatic word_t enc_b(logic [2:0] f3, word_t off, reg_addr_t rs1, reg_addr_t rs2);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
   endfunction

   function automatic retire_t mk_ret(word_t pc, reg_addr_t rd, word_t value, logic wrote);
      retire_t r;
      r.pc    = pc;
      r.rd    = rd;
      r.value = value;
      r.wrote = wrote;
      return r;
   endfunction

   // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic load_program();
      for (int i = 0; i < imem_words; i++) begin
         imem[i] = {25'(i) ^ 25'h0A5A5A5, 7'b0001011};  // Custom opcode that decodes as a no-op
      end
      imem[0]  = enc_i(5, 0, 1);
      imem[1]  = enc_i(-7, 1, 2);                     // Depends on the previous write
      imem[2]  = enc_r(funct7_add, 2, 1, 3);
      imem[3]  = enc_r(funct7_sub, 1, 2, 4);
      imem[4]  = enc_u(20'h80000, 5);
      imem[5]  = enc_r(funct7_add, 5, 5, 6);          // Wraps to zero
      imem[6]  = enc_i(9, 1, 0);                      // Write to x0 is dropped
      imem[7]  = enc_r(funct7_add, 1, 0, 7);
      imem[8]  = enc_j(12, 8);
      imem[9]  = enc_i(1, 0, 9);                      // Skipped by the JAL
      imem[10] = enc_i(2, 0, 9);
      imem[11] = enc_b(funct3_beq, 8, 1, 7);          // Taken
      imem[12] = enc_i(3, 0, 10);
      imem[13] = enc_b(funct3_bne, 8, 1, 7);          // Not taken
      imem[14] = enc_b(funct3_beq, 8, 3, 0);          // Not taken
      imem[15] = enc_b(funct3_bne, 8, 3, 0);          // Taken
      imem[16] = enc_i(4, 0, 10);
      imem[17] = enc_u(20'h12345, 11);
      imem[18] = enc_i(12'h678, 11, 11);
      imem[19] = enc_r(funct7_sub, 11, 0, 12);
      imem[20] = enc_j(0, 0);                         // Jump to itself
   endtask

   task automatic load_expected();
      exp_tab[0]  = mk_ret(32'h00, 1,  32'h0000_0005, 1'b1);
      exp_tab[1]  = mk_ret(32'h04, 2,  32'hFFFF_FFFE, 1'b1);
      exp_tab[2]  = mk_ret(32'h08, 3,  32'h0000_0003, 1'b1);
      exp_tab[3]  = mk_ret(32'h0C, 4,  32'hFFFF_FFF9, 1'b1);
      exp_tab[4]  = mk_ret(32'h10, 5,  32'h8000_0000, 1'b1);
      exp_tab[5]  = mk_ret(32'h14, 6,  32'h0000_0000, 1'b1);
      exp_tab[6]  = mk_ret(32'h18, 0,  32'h0000_0000, 1'b0);
      exp_tab[7]  = mk_ret(32'h1C, 7,  32'h0000_0005, 1'b1);
      exp_tab[8]  = mk_ret(32'h20, 8,  32'h0000_0024, 1'b1);
      exp_tab[9]  = mk_ret(32'h2C, 0,  32'h0000_0000, 1'b0);
      exp_tab[10] = mk_ret(32'h34, 0,  32'h0000_0000, 1'b0);
      exp_tab[11] = mk_ret(32'h38, 0,  32'h0000_0000, 1'b0);
      exp_tab[12] = mk_ret(32'h3C, 0,  32'h0000_0000, 1'b0);
      exp_tab[13] = mk_ret(32'h44, 11, 32'h1234_5000, 1'b1);
      exp_tab[14] = mk_ret(32'h48, 11, 32'h1234_5678, 1'b1);
      exp_tab[15] = mk_ret(32'h4C, 12, 32'hEDCB_A988, 1'b1);
      exp_tab[16] = mk_ret(32'h50, 0,  32'h0000_0000, 1'b0);
      exp_tab[17] = mk_ret(32'h50, 0,  32'h0000_0000, 1'b0);
      // A break in sequential pc order means a redirect to the next row's pc
      for (int i = 0; i < n_rows - 1; i++) begin
         if (exp_tab[i + 1].pc != exp_tab[i].pc + 32'd4) begin
            redir_q.push_back(exp_tab[i + 1].pc);
         end
      end
   endtask

   // ==============================
   // Compare tasks
   // ==============================
   task automatic check_retire(retire_t act, retire_t want, string what);
      if (act.pc !== want.pc) begin
         $display("mismatch at %0t ns: %s pc %08h, expected %08h", $time, what, act.pc, want.pc);
         errors++;
      end
      if (act.rd !== want.rd) begin
         $display("mismatch at %0t ns: %s rd %0d, expected %0d", $time, what, act.rd, want.rd);
         errors++;
      end
      if (act.value !== want.value) begin
         $display("mismatch at %0t ns: %s value %08h, expected %08h",
                  $time, what, act.value, want.value);
         errors++;
      end
      if (act.wrote !== want.wrote) begin
         $display("mismatch at %0t ns: %s wrote %0b, expected %0b",
                  $time, what, act.wrote, want.wrote);
         errors++;
      end
   endtask

   task automatic check_pc(word_t act, word_t want, string what);
      if (act !== want) begin
         $display("mismatch at %0t ns: %s address %08h, expected %08h", $time, what, act, want);
         errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Memory answers one cycle after each request
   always @(posedge clk) begin
      if (imem_req) begin
         imem_data <= imem[imem_addr[7:2]];
      end
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         retire_ready <= 1'b0;
      end else begin
         lfsr = lfsr_step(lfsr);
         retire_ready <= lfsr[0];
         lfsr = lfsr_step(lfsr);
         if (lfsr[0]) begin
            retire_ready <= 1'b1;   // Two bits ORed, so ready about three cycles in four
         end
      end
   end

   // ==============================
   // Monitors sampled mid-cycle
   // ==============================
   always @(negedge clk) begin
      if (!rst_n && (retire_valid || imem_req)) begin
         $display("retire_valid or imem_req was high during reset at %0t ns", $time);
         errors++;
      end
      if (rst_n && imem_req && !first_req_done) begin
         check_pc(imem_addr, reset_pc, "first fetch");
         first_req_done = 1'b1;
      end
      if (redirect_seen) begin
         if (!imem_req) begin
            $display("no fetch request in the cycle after a redirect at %0t ns", $time);
            errors++;
         end else if (redir_q.size() > 0) begin
            check_pc(imem_addr, redir_q.pop_front(), "redirect target");
         end
      end
      if (stall_seen) begin
         if (!retire_valid) begin
            $display("retire_valid dropped while stalled at %0t ns", $time);
            errors++;
         end else begin
            check_retire(retire, held, "stalled record");
         end
      end
      redirect_seen = rst_n && dut0.redirect.valid;
      stall_seen    = rst_n && retire_valid && !retire_ready;
      held          = retire;
   end

   initial begin
      #(timeout_cycles * clk_period);
      $display("timeout: the retire sequence did not finish in %0d cycles", timeout_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int errors_before;
      rst_n          = 1'b0;
      retire_ready   = 1'b0;
      imem_data      = '0;
      lfsr           = 16'd94;
      errors         = 0;
      redirect_seen  = 1'b0;
      stall_seen     = 1'b0;
      first_req_done = 1'b0;
      load_program();
      load_expected();
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < n_rows; i++) begin
         errors_before = errors;
         do begin
            @(negedge clk);
         end while (!(retire_valid && retire_ready));   // Transfer at the next edge
         check_retire(retire, exp_tab[i], $sformatf("row %0d", i));
         $display("test %0d pc %08h: %s", i, exp_tab[i].pc,
                  (errors == errors_before) ? "ok" : "failed");
      end
      @(negedge clk);
      if (redir_q.size() != 0) begin
         $display("%0d expected redirects never happened", redir_q.size());
         errors++;
      end

      $display("%0d tests run, %0d errors", n_rows, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
